// File: source/DispatchTypes.sv
// ==================================================
// Types for renamed micro-ops arriving at dispatch.
// Shared by the rename-side feeder, the dispatch
// lanes and the lane interface.
// ==================================================

package DispatchTypes;

    // Target queue class of a micro-op
    typedef enum logic [1:0] {
        MopInt,
        MopComplex,
        MopMem
    } MopType;

    typedef enum logic [1:0] {
        IntAlu,
        IntBr,
        IntJalr
    } IntOpCode;

    typedef enum logic {
        ComplexMul,
        ComplexDiv
    } ComplexOpCode;

    typedef enum logic {
        MemLoad,
        MemStore
    } MemOpCode;

    typedef enum logic [1:0] {
        OperandReg,
        OperandImm,
        OperandPc
    } OperandType;

    // subCode holds the opcode of whichever class mopType names
    typedef struct packed {
        MopType      mopType;
        logic [1:0]  subCode;
        OperandType  opTypeA;
        OperandType  opTypeB;
        logic [5:0]  phySrcA;
        logic [5:0]  phySrcB;
        logic [5:0]  phyDst;
        logic        writeReg;
        logic [11:0] imm;
        logic [3:0]  aluCode;
        logic        brPred;
        logic        mulUpper;
        logic [4:0]  activeListPtr;
    } RenamedOp;

    // Flattened width of one op on the top-level group port
    localparam int RenamedOpBits = $bits(RenamedOp);

endpackage

// File: source/SchedulerTypes.sv
// ==================================================
// Payload formats held by the integer, complex and
// memory issue queues, plus the pop-port queue select.
// ==================================================

package SchedulerTypes;

    typedef enum logic [1:0] {
        QueueInt,
        QueueComplex,
        QueueMem
    } QueueKind;

    localparam int QueueKinds = 3;

    // Shared field width of the branch and ALU formats
    localparam int SubInfoBits = 22;

    typedef struct packed {
        logic [11:0]               brDisp;
        logic                      bPred;
        DispatchTypes::OperandType opTypeA;
        DispatchTypes::OperandType opTypeB;
        logic [SubInfoBits-18:0]   padding;
    } BrSubInfo;

    typedef struct packed {
        DispatchTypes::OperandType opTypeA;
        DispatchTypes::OperandType opTypeB;
        logic [11:0]               imm;
        logic [3:0]                aluCode;
        logic [SubInfoBits-21:0]   padding;
    } IntSubInfo;

    typedef union packed {
        BrSubInfo  br;
        IntSubInfo alu;
    } IntOpInfo;

    typedef struct packed {
        logic mulUpper;
        logic zero;
    } MulSubInfo;

    typedef struct packed {
        logic zero;
        logic isSigned;
    } DivSubInfo;

    typedef union packed {
        MulSubInfo mul;
        DivSubInfo div;
    } ComplexOpInfo;

    // Fields every queue keeps, including wake-up flags
    typedef struct packed {
        logic [5:0] phySrcA;
        logic [5:0] phySrcB;
        logic [5:0] phyDst;
        logic       writeReg;
        logic       srcValidA;
        logic       srcValidB;
        logic [4:0] activeListPtr;
    } EntryCommon;

    typedef struct packed {
        EntryCommon              common;
        DispatchTypes::IntOpCode opCode;
        IntOpInfo                subInfo;
    } IntQueueEntry;

    typedef struct packed {
        EntryCommon                  common;
        DispatchTypes::ComplexOpCode opCode;
        ComplexOpInfo                subInfo;
    } ComplexQueueEntry;

    typedef struct packed {
        EntryCommon              common;
        DispatchTypes::MemOpCode opCode;
        logic [11:0]             imm;
        logic                    isRegAddr;
    } MemQueueEntry;

    localparam int IntEntryBits = $bits(IntQueueEntry);
    localparam int ComplexEntryBits = $bits(ComplexQueueEntry);
    localparam int MemEntryBits = $bits(MemQueueEntry);
    localparam int WiderBits = (IntEntryBits > ComplexEntryBits) ? IntEntryBits : ComplexEntryBits;

    // Pop data width, narrower entries zero-extended
    localparam int QueueEntryBits = (WiderBits > MemEntryBits) ? WiderBits : MemEntryBits;

endpackage

// File: source/DispatchLaneIf.sv
// ==================================================
// Per-lane link: the feeder hands one renamed op to
// its lane, and the lane hands the formatted queue
// entries on to the queue writer.
// ==================================================

interface DispatchLaneIf;

    logic                            valid;
    DispatchTypes::RenamedOp         op;

    logic                            entryValid;
    SchedulerTypes::QueueKind        kind;
    SchedulerTypes::IntQueueEntry    intEntry;
    SchedulerTypes::ComplexQueueEntry complexEntry;
    SchedulerTypes::MemQueueEntry    memEntry;

    modport feed (
        output valid,
        output op
    );

    modport lane (
        input  valid,
        input  op,
        output entryValid,
        output kind,
        output intEntry,
        output complexEntry,
        output memEntry
    );

    modport sink (
        input entryValid,
        input kind,
        input intEntry,
        input complexEntry,
        input memEntry
    );

endinterface

// File: source/RenameFeed.sv
// ==================================================
// Rename-side feeder. Takes a group by four-phase
// req/ack once every queue has credit for it, then
// presents the group to the lanes for one cycle.
// ==================================================

module RenameFeed #(
    parameter int dispatchWidth = 2,
    parameter int queueDepth = 8
) (
    input  logic                                       ctrl,
    input  logic                                       rstN,
    input  logic                                       flush,
    input  logic                                       groupReq,
    output logic                                       groupAck,
    input  logic [dispatchWidth-1:0]                   groupValid,
    input  DispatchTypes::RenamedOp [dispatchWidth-1:0] groupOps,
    input  logic [SchedulerTypes::QueueKinds-1:0]      freed,
    DispatchLaneIf.feed                                lanes [dispatchWidth]
);

    localparam int CreditBits = $clog2(queueDepth + 1);

    typedef enum logic [1:0] {
        Idle,
        Acked,
        WaitDrop
    } FeedState;

    FeedState                         state;
    logic [CreditBits-1:0]            credit [SchedulerTypes::QueueKinds];
    logic [CreditBits-1:0]            need [SchedulerTypes::QueueKinds];
    logic                             fits;
    logic                             capture;
    logic [dispatchWidth-1:0]         laneValid;
    DispatchTypes::RenamedOp [dispatchWidth-1:0] laneOp;

    // Op classes and queue kinds share one encoding
    always_comb begin
        for (int k = 0; k < SchedulerTypes::QueueKinds; k++) begin
            need[k] = '0;
        end
        for (int i = 0; i < dispatchWidth; i++) begin
            if (groupValid[i]) begin
                need[groupOps[i].mopType] = need[groupOps[i].mopType] + 1'b1;
            end
        end
        fits = 1'b1;
        for (int k = 0; k < SchedulerTypes::QueueKinds; k++) begin
            if (need[k] > credit[k]) begin
                fits = 1'b0;
            end
        end
    end

    assign capture = (state == Idle) && groupReq && fits && !flush;
    assign groupAck = (state != Idle);

    // Acked is the cycle the group sits in the feeder register
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            case (state)
                Idle:     if (capture) state <= Acked;
                Acked:    state <= WaitDrop;
                WaitDrop: if (!groupReq) state <= Idle;
                default:  state <= Idle;
            endcase
        end
    end

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < SchedulerTypes::QueueKinds; k++) begin
                credit[k] <= CreditBits'(queueDepth);
            end
        end else if (flush) begin
            for (int k = 0; k < SchedulerTypes::QueueKinds; k++) begin
                credit[k] <= CreditBits'(queueDepth);
            end
        end else begin
            for (int k = 0; k < SchedulerTypes::QueueKinds; k++) begin
                credit[k] <= credit[k] - (capture ? need[k] : '0) + CreditBits'(freed[k]);
            end
        end
    end

    // Lane valids last one cycle per captured group
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            laneValid <= '0;
        end else if (flush) begin
            laneValid <= '0;
        end else begin
            laneValid <= capture ? groupValid : '0;
        end
    end

    always_ff @(posedge ctrl) begin
        if (capture) begin
            laneOp <= groupOps;
        end
    end

    for (genvar i = 0; i < dispatchWidth; i++) begin : gLaneOut
        assign lanes[i].valid = laneValid[i];
        assign lanes[i].op = laneOp[i];
    end

    // Returned credits must match what the writer removed
    for (genvar k = 0; k < SchedulerTypes::QueueKinds; k++) begin : gCreditCheck
        assert property (@(posedge ctrl) disable iff (!rstN) credit[k] <= queueDepth)
            else $error("credit of queue %0d above queue depth", k);
    end

endmodule

// File: source/DispatchLane.sv
// ==================================================
// One dispatch lane. Registers the op from the feeder
// and reformats it into the payload of the int,
// complex or memory issue queue.
// ==================================================

module DispatchLane (
    input logic         ctrl,
    input logic         rstN,
    input logic         flush,
    DispatchLaneIf.lane port
);

    logic                         opValid;
    DispatchTypes::RenamedOp      opReg;
    SchedulerTypes::EntryCommon   common;
    SchedulerTypes::BrSubInfo     brInfo;
    SchedulerTypes::IntSubInfo    aluInfo;
    SchedulerTypes::MulSubInfo    mulInfo;
    SchedulerTypes::DivSubInfo    divInfo;
    DispatchTypes::IntOpCode      intCode;

    // ALU sub-info is overlaid on the branch sub-info field
    if ($bits(SchedulerTypes::IntSubInfo) > $bits(SchedulerTypes::BrSubInfo)) begin : gPadCheck
        $error("IntSubInfo is wider than BrSubInfo");
    end

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else if (flush) begin
            opValid <= 1'b0;
        end else begin
            opValid <= port.valid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (port.valid) begin
            opReg <= port.op;
        end
    end

    always_comb begin
        common.phySrcA = opReg.phySrcA;
        common.phySrcB = opReg.phySrcB;
        common.phyDst = opReg.phyDst;
        common.writeReg = opReg.writeReg;
        // Wake-up is only needed for register sources
        common.srcValidA = (opReg.opTypeA == DispatchTypes::OperandReg);
        common.srcValidB = (opReg.opTypeB == DispatchTypes::OperandReg);
        common.activeListPtr = opReg.activeListPtr;

        brInfo.brDisp = opReg.imm;
        brInfo.bPred = opReg.brPred;
        brInfo.opTypeA = opReg.opTypeA;
        brInfo.opTypeB = opReg.opTypeB;
        brInfo.padding = '0;

        aluInfo.opTypeA = opReg.opTypeA;
        aluInfo.opTypeB = opReg.opTypeB;
        aluInfo.imm = opReg.imm;
        aluInfo.aluCode = opReg.aluCode;
        aluInfo.padding = '0;

        mulInfo.mulUpper = opReg.mulUpper;
        mulInfo.zero = 1'b0;
        divInfo.zero = 1'b0;
        divInfo.isSigned = opReg.aluCode[0];

        // Integer queue
        intCode = DispatchTypes::IntOpCode'(opReg.subCode);
        port.intEntry.common = common;
        port.intEntry.opCode = intCode;
        if (intCode == DispatchTypes::IntBr || intCode == DispatchTypes::IntJalr) begin
            port.intEntry.subInfo.br = brInfo;
        end else begin
            port.intEntry.subInfo.alu = aluInfo;
        end

        // Complex queue
        port.complexEntry.common = common;
        port.complexEntry.opCode = DispatchTypes::ComplexOpCode'(opReg.subCode[0]);
        if (port.complexEntry.opCode == DispatchTypes::ComplexMul) begin
            port.complexEntry.subInfo.mul = mulInfo;
        end else begin
            port.complexEntry.subInfo.div = divInfo;
        end

        // Memory queue
        port.memEntry.common = common;
        port.memEntry.opCode = DispatchTypes::MemOpCode'(opReg.subCode[0]);
        port.memEntry.imm = opReg.imm;
        port.memEntry.isRegAddr = (opReg.opTypeA == DispatchTypes::OperandReg);
    end

    assign port.entryValid = opValid;
    // Same encoding as the op class
    assign port.kind = SchedulerTypes::QueueKind'(opReg.mopType);

endmodule

// File: source/IssueQueueWriter.sv
// ==================================================
// Integer, complex and memory issue queues as FIFOs.
// Lane entries are written in lane order; the drain
// removes heads through a four-phase pop port.
// ==================================================

module IssueQueueWriter #(
    parameter int dispatchWidth = 2,
    parameter int queueDepth = 8
) (
    input  logic                                       ctrl,
    input  logic                                       rstN,
    input  logic                                       flush,
    DispatchLaneIf.sink                                lanes [dispatchWidth],
    input  logic                                       popReq,
    input  SchedulerTypes::QueueKind                   popQueue,
    output logic                                       popAck,
    output logic                                       popHit,
    output logic [SchedulerTypes::QueueEntryBits-1:0]  popData,
    output logic [SchedulerTypes::QueueKinds-1:0]      freed
);

    localparam int PtrBits = $clog2(queueDepth);
    localparam int CountBits = $clog2(queueDepth + 1);
    localparam int EntryBits = SchedulerTypes::QueueEntryBits;
    localparam int Kinds = SchedulerTypes::QueueKinds;

    typedef enum logic {
        PopIdle,
        PopHold
    } PopState;

    logic [EntryBits-1:0]     mem [Kinds][queueDepth];
    logic [PtrBits-1:0]       head [Kinds];
    logic [PtrBits-1:0]       tail [Kinds];
    logic [CountBits-1:0]     count [Kinds];
    logic [CountBits-1:0]     pushCount [Kinds];
    logic [dispatchWidth-1:0] laneValid;
    SchedulerTypes::QueueKind laneKind [dispatchWidth];
    logic [EntryBits-1:0]     laneData [dispatchWidth];
    logic [PtrBits-1:0]       wrSlot [dispatchWidth];
    PopState                  popState;
    logic                     popGo;
    logic [Kinds-1:0]         popDo;

    for (genvar i = 0; i < dispatchWidth; i++) begin : gLaneIn
        assign laneValid[i] = lanes[i].entryValid;
        assign laneKind[i] = lanes[i].kind;
        assign laneData[i] = (lanes[i].kind == SchedulerTypes::QueueInt) ?
                                 EntryBits'(lanes[i].intEntry) :
                             (lanes[i].kind == SchedulerTypes::QueueComplex) ?
                                 EntryBits'(lanes[i].complexEntry) :
                                 EntryBits'(lanes[i].memEntry);
    end

    // Later lanes land behind earlier lanes of the same queue
    always_comb begin
        for (int k = 0; k < Kinds; k++) begin
            pushCount[k] = '0;
        end
        for (int i = 0; i < dispatchWidth; i++) begin
            wrSlot[i] = PtrBits'(tail[laneKind[i]] + pushCount[laneKind[i]]);
            if (laneValid[i]) begin
                pushCount[laneKind[i]] = pushCount[laneKind[i]] + 1'b1;
            end
        end
    end

    always_ff @(posedge ctrl) begin
        for (int i = 0; i < dispatchWidth; i++) begin
            if (laneValid[i]) begin
                mem[laneKind[i]][wrSlot[i]] <= laneData[i];
            end
        end
    end

    assign popGo = (popState == PopIdle) && popReq;

    always_comb begin
        for (int k = 0; k < Kinds; k++) begin
            popDo[k] = popGo && !flush && (popQueue == SchedulerTypes::QueueKind'(k)) &&
                       (count[k] != '0);
        end
    end

    // One credit back per removed entry
    assign freed = popDo;

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < Kinds; k++) begin
                head[k] <= '0;
                tail[k] <= '0;
                count[k] <= '0;
            end
        end else if (flush) begin
            for (int k = 0; k < Kinds; k++) begin
                head[k] <= '0;
                tail[k] <= '0;
                count[k] <= '0;
            end
        end else begin
            for (int k = 0; k < Kinds; k++) begin
                head[k] <= head[k] + PtrBits'(popDo[k]);
                tail[k] <= tail[k] + PtrBits'(pushCount[k]);
                count[k] <= count[k] + pushCount[k] - CountBits'(popDo[k]);
            end
        end
    end

    // Pop handshake, ack one cycle after the request
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            popState <= PopIdle;
            popHit <= 1'b0;
        end else begin
            case (popState)
                PopIdle: begin
                    if (popReq) begin
                        popState <= PopHold;
                        popHit <= |popDo;
                    end
                end
                PopHold: if (!popReq) popState <= PopIdle;
                default: popState <= PopIdle;
            endcase
        end
    end

    assign popAck = (popState == PopHold);

    always_ff @(posedge ctrl) begin
        if (popGo) begin
            popData <= mem[popQueue][head[popQueue]];
        end
    end

    // Feeder credits must keep every write inside its queue
    for (genvar k = 0; k < Kinds; k++) begin : gFullCheck
        assert property (@(posedge ctrl) disable iff (!rstN)
            (count[k] + pushCount[k]) <= queueDepth)
            else $error("write into full queue %0d", k);
    end

endmodule

// File: source/DispatchUnit.sv
// ==================================================
// Dispatch unit top level. Joins the rename feeder,
// the dispatch lanes and the issue queue writer; the
// group and pop handshakes are plain ports.
// ==================================================

module DispatchUnit #(
    parameter int dispatchWidth = 2,
    parameter int queueDepth = 8
) (
    input  logic                                              ctrl,
    input  logic                                              rstN,
    input  logic                                              flush,
    input  logic                                              groupReq,
    output logic                                              groupAck,
    input  logic [dispatchWidth-1:0]                          groupValid,
    input  logic [dispatchWidth*DispatchTypes::RenamedOpBits-1:0] groupOps,
    input  logic                                              popReq,
    input  SchedulerTypes::QueueKind                          popQueue,
    output logic                                              popAck,
    output logic                                              popHit,
    output logic [SchedulerTypes::QueueEntryBits-1:0]         popData
);

    logic [SchedulerTypes::QueueKinds-1:0] freed;

    DispatchLaneIf laneIf [dispatchWidth] ();

    RenameFeed #(
        .dispatchWidth(dispatchWidth),
        .queueDepth(queueDepth)
    ) uFeed (
        .ctrl(ctrl),
        .rstN(rstN),
        .flush(flush),
        .groupReq(groupReq),
        .groupAck(groupAck),
        .groupValid(groupValid),
        .groupOps(groupOps),
        .freed(freed),
        .lanes(laneIf)
    );

    for (genvar i = 0; i < dispatchWidth; i++) begin : gLane
        DispatchLane uLane (
            .ctrl(ctrl),
            .rstN(rstN),
            .flush(flush),
            .port(laneIf[i])
        );
    end

    IssueQueueWriter #(
        .dispatchWidth(dispatchWidth),
        .queueDepth(queueDepth)
    ) uWriter (
        .ctrl(ctrl),
        .rstN(rstN),
        .flush(flush),
        .lanes(laneIf),
        .popReq(popReq),
        .popQueue(popQueue),
        .popAck(popAck),
        .popHit(popHit),
        .popData(popData),
        .freed(freed)
    );

endmodule

// File: tb/DispatchUnitTb.sv
// ==================================================
// Testbench for the dispatch unit. Sends random and
// directed groups, keeps a model of the three issue
// queues and checks every pop with assertions.
// ==================================================

module DispatchUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Lanes = 2;
    localparam int Depth = 8;
    localparam int OpBits = DispatchTypes::RenamedOpBits;
    localparam int EntryBits = SchedulerTypes::QueueEntryBits;
    localparam int Rounds = 20;
    // Random rounds plus back-pressure and flush groups
    localparam int Groups = Rounds * 3 + 12;
    localparam int CycleLimit = 40 * Groups + 200;

    logic                            ctrl;
    logic                            rstN;
    logic                            flush;
    logic                            groupReq;
    logic                            groupAck;
    logic [Lanes-1:0]                groupValid;
    logic [Lanes*OpBits-1:0]         groupOps;
    logic                            popReq;
    SchedulerTypes::QueueKind        popQueue;
    logic                            popAck;
    logic                            popHit;
    logic [EntryBits-1:0]            popData;

    int                              seed = 32'ha62801b1;
    int                              cycles = 0;
    int                              opCount;
    logic                            expHit;
    logic [EntryBits-1:0]            expData;
    logic                            noAckExpected;
    logic [Lanes-1:0]                pendValid;
    DispatchTypes::RenamedOp [Lanes-1:0] pendGrp;
    logic [EntryBits-1:0]            intQ [$];
    logic [EntryBits-1:0]            cplxQ [$];
    logic [EntryBits-1:0]            memQ [$];

    DispatchUnit #(
        .dispatchWidth(Lanes),
        .queueDepth(Depth)
    ) i_dut (
        .ctrl(ctrl),
        .rstN(rstN),
        .flush(flush),
        .groupReq(groupReq),
        .groupAck(groupAck),
        .groupValid(groupValid),
        .groupOps(groupOps),
        .popReq(popReq),
        .popQueue(popQueue),
        .popAck(popAck),
        .popHit(popHit),
        .popData(popData)
    );

    initial ctrl = 1'b0;
    always #2 ctrl = ~ctrl;

    always @(posedge ctrl) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout, handshake stalled");
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // Pop results are registered at the ack edge and checked one edge later
    popHitCheck: assert property (@(posedge ctrl) disable iff (!rstN)
        $rose(popAck) |-> popHit == expHit)
        else begin
            $display("Fail popHit expected %h actual %h", expHit, popHit);
            $display("Simulation failed");
            $fatal(1, "pop hit mismatch");
        end

    popDataCheck: assert property (@(posedge ctrl) disable iff (!rstN)
        ($rose(popAck) && expHit) |-> popData == expData)
        else begin
            $display("Fail popData expected %h actual %h", expData, popData);
            $display("Simulation failed");
            $fatal(1, "pop data mismatch");
        end

    noAckCheck: assert property (@(posedge ctrl) disable iff (!rstN)
        noAckExpected |-> !groupAck)
        else begin
            $display("Fail groupAck expected %h actual %h", 1'b0, groupAck);
            $display("Simulation failed");
            $fatal(1, "group acked into a full queue");
        end

    // First 18 ops walk all classes, opcodes and operand types
    function automatic DispatchTypes::RenamedOp makeOp(input int n, input int forceCls);
        DispatchTypes::RenamedOp op;
        logic [31:0] r;
        int cls;
        int sub;
        int opA;
        int opB;
        r = $random(seed);
        if (n < 18) begin
            cls = n % 3;
            sub = n / 3;
            opA = (n / 3) % 3;
            opB = (n / 2) % 3;
        end else begin
            cls = r[1:0] % 3;
            sub = r[3:2];
            opA = r[4] ? 0 : 1 + r[5];
            opB = r[6] ? 0 : 1 + r[7];
        end
        if (forceCls >= 0) cls = forceCls;
        sub = (cls == 0) ? sub % 3 : sub % 2;
        op.mopType = DispatchTypes::MopType'(2'(cls));
        op.subCode = 2'(sub);
        op.opTypeA = DispatchTypes::OperandType'(2'(opA));
        op.opTypeB = DispatchTypes::OperandType'(2'(opB));
        r = $random(seed);
        op.phySrcA = r[5:0];
        op.phySrcB = r[11:6];
        op.phyDst = r[17:12];
        op.writeReg = r[18];
        op.aluCode = r[22:19];
        op.brPred = r[23];
        op.mulUpper = r[24];
        op.activeListPtr = r[29:25];
        r = $random(seed);
        op.imm = r[11:0];
        return op;
    endfunction

    // Queue payload built field by field and zero-extended to the pop width
    function automatic logic [EntryBits-1:0] expectEntry(input DispatchTypes::RenamedOp op);
        logic [25:0] common;
        logic [21:0] sub;
        logic [EntryBits-1:0] e;
        common = {op.phySrcA, op.phySrcB, op.phyDst, op.writeReg,
                  op.opTypeA == DispatchTypes::OperandReg,
                  op.opTypeB == DispatchTypes::OperandReg, op.activeListPtr};
        if (op.mopType == DispatchTypes::MopInt) begin
            if (op.subCode == DispatchTypes::IntBr || op.subCode == DispatchTypes::IntJalr) begin
                sub = {op.imm, op.brPred, op.opTypeA, op.opTypeB, 5'b0};
            end else begin
                sub = {op.opTypeA, op.opTypeB, op.imm, op.aluCode, 2'b0};
            end
            e = EntryBits'({common, op.subCode, sub});
        end else if (op.mopType == DispatchTypes::MopComplex) begin
            if (op.subCode[0] == 1'b0) begin
                e = EntryBits'({common, 1'b0, op.mulUpper, 1'b0});
            end else begin
                e = EntryBits'({common, 1'b1, 1'b0, op.aluCode[0]});
            end
        end else begin
            e = EntryBits'({common, op.subCode[0], op.imm,
                            op.opTypeA == DispatchTypes::OperandReg});
        end
        return e;
    endfunction

    task automatic pushModel(input DispatchTypes::RenamedOp op);
        case (op.mopType)
            DispatchTypes::MopInt:     intQ.push_back(expectEntry(op));
            DispatchTypes::MopComplex: cplxQ.push_back(expectEntry(op));
            default:                   memQ.push_back(expectEntry(op));
        endcase
    endtask

    task automatic takeExpected(input int k, output logic hit, output logic [EntryBits-1:0] data);
        hit = 1'b0;
        data = '0;
        if (k == 0 && intQ.size() > 0) begin
            hit = 1'b1;
            data = intQ.pop_front();
        end else if (k == 1 && cplxQ.size() > 0) begin
            hit = 1'b1;
            data = cplxQ.pop_front();
        end else if (k == 2 && memQ.size() > 0) begin
            hit = 1'b1;
            data = memQ.pop_front();
        end
    endtask

    task automatic startGroup(input logic [Lanes-1:0] valid,
                              input DispatchTypes::RenamedOp [Lanes-1:0] grp);
        pendValid = valid;
        pendGrp = grp;
        groupValid = valid;
        groupOps = grp;
        groupReq = 1'b1;
    endtask

    task automatic completeGroup();
        do begin
            @(posedge ctrl);
            #0.5;
        end while (!groupAck);
        for (int i = 0; i < Lanes; i++) begin
            if (pendValid[i]) pushModel(pendGrp[i]);
        end
        groupReq = 1'b0;
        do begin
            @(posedge ctrl);
            #0.5;
        end while (groupAck);
    endtask

    task automatic sendGroup(input logic [Lanes-1:0] valid,
                             input DispatchTypes::RenamedOp [Lanes-1:0] grp);
        startGroup(valid, grp);
        completeGroup();
    endtask

    task automatic randomGroup();
        logic [31:0] r;
        logic [Lanes-1:0] valid;
        DispatchTypes::RenamedOp [Lanes-1:0] grp;
        r = $random(seed);
        if (opCount < 18) valid = '1;
        else if (r[1:0] == 2'd0) valid = '0;
        else if (r[1:0] == 2'd1) valid = Lanes'(1);
        else valid = '1;
        for (int i = 0; i < Lanes; i++) begin
            grp[i] = makeOp(opCount, -1);
            opCount++;
        end
        sendGroup(valid, grp);
    endtask

    task automatic fillClass(input int cls, input int groups);
        DispatchTypes::RenamedOp [Lanes-1:0] grp;
        for (int g = 0; g < groups; g++) begin
            for (int i = 0; i < Lanes; i++) begin
                grp[i] = makeOp(opCount, cls);
                opCount++;
            end
            sendGroup('1, grp);
        end
    endtask

    task automatic popCheck(input int k);
        logic hit;
        logic [EntryBits-1:0] data;
        takeExpected(k, hit, data);
        expHit = hit;
        expData = data;
        popQueue = SchedulerTypes::QueueKind'(2'(k));
        popReq = 1'b1;
        do begin
            @(posedge ctrl);
            #0.5;
        end while (!popAck);
        popReq = 1'b0;
        do begin
            @(posedge ctrl);
            #0.5;
        end while (popAck);
    endtask

    // Empties every queue and ends each with a pop that must miss
    task automatic drainAll();
        for (int k = 0; k < 3; k++) begin
            while ((k == 0 && intQ.size() > 0) || (k == 1 && cplxQ.size() > 0) ||
                   (k == 2 && memQ.size() > 0)) begin
                popCheck(k);
            end
            popCheck(k);
        end
    endtask

    task automatic pulseFlush();
        flush = 1'b1;
        @(posedge ctrl);
        #0.5;
        flush = 1'b0;
        intQ.delete();
        cplxQ.delete();
        memQ.delete();
    endtask

    initial begin
        DispatchTypes::RenamedOp [Lanes-1:0] grp;
        rstN = 1'b0;
        flush = 1'b0;
        groupReq = 1'b0;
        groupValid = '0;
        groupOps = '0;
        popReq = 1'b0;
        popQueue = SchedulerTypes::QueueInt;
        expHit = 1'b0;
        expData = '0;
        noAckExpected = 1'b0;
        pendValid = '0;
        pendGrp = '0;
        opCount = 0;
        repeat (16) @(posedge ctrl);
        #0.5;
        rstN = 1'b1;

        // Routing, order and packing
        for (int n = 0; n < Rounds; n++) begin
            repeat (3) randomGroup();
            drainAll();
        end

        // Next int group must wait for one pop once the integer queue is full
        fillClass(0, Depth / Lanes);
        for (int i = 0; i < Lanes; i++) begin
            grp[i] = makeOp(opCount, 0);
            opCount++;
        end
        noAckExpected = 1'b1;
        startGroup(Lanes'(1), grp);
        repeat (12) begin
            @(posedge ctrl);
            #0.5;
        end
        noAckExpected = 1'b0;
        popCheck(0);
        completeGroup();
        drainAll();

        // Flush drops queued entries and restores full credit
        fillClass(2, 2);
        randomGroup();
        pulseFlush();
        for (int k = 0; k < 3; k++) begin
            popCheck(k);
        end
        fillClass(2, Depth / Lanes);
        drainAll();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: build.f
source/DispatchTypes.sv
source/SchedulerTypes.sv
source/DispatchLaneIf.sv
source/RenameFeed.sv
source/DispatchLane.sv
source/IssueQueueWriter.sv
source/DispatchUnit.sv
tb/DispatchUnitTb.sv

// File: Makefile
# Verilator build and run for the dispatch unit testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= DispatchUnitTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
